// File: rs_defs.svh
`ifndef RS_DEFS_SVH
`define RS_DEFS_SVH

// Reservation station depth
`define RS_NUM_ENTS 8

// Physical register file
`define RS_PRF_ENTS 32
`define RS_XLEN 32

// Writeback ports into the PRF and wakeup logic
`define RS_NUM_WB 2

`define RS_ROBID_W 5

// Cycles between the stall decision and the entry write
`define RS_PIPE_SLACK 1

`endif

// File: rs_pkg.sv
`include "rs_defs.svh"

package rs_pkg;

    typedef logic [`RS_XLEN-1:0] rs_data_t;
    typedef logic [$clog2(`RS_PRF_ENTS)-1:0] rs_prf_id_t;
    typedef logic [`RS_ROBID_W-1:0] rs_robid_t;
    typedef logic [`RS_NUM_ENTS-1:0] rs_ent_vec_t;
    typedef logic [3:0] rs_opcode_t;

    // Where an operand value comes from
    typedef enum logic [1:0] {
        OP_ZERO,
        OP_IMM,
        OP_REG
    } rs_optype_t;

    typedef enum logic {
        FU_EXE,
        FU_MEM
    } rs_fu_t;

    typedef struct packed {
        rs_optype_t optype;
        rs_prf_id_t psrc;
        logic       ready;
    } rs_src_t;

    typedef struct packed {
        rs_robid_t  robid;
        rs_fu_t     fu;
        rs_opcode_t opcode;
        rs_prf_id_t pdst;
        rs_src_t    src1;
        rs_src_t    src2;
        rs_data_t   imm;
    } rs_disp_pkt_t;

    typedef struct packed {
        rs_prf_id_t pdst;
        rs_data_t   data;
    } rs_wb_pkt_t;

    typedef struct packed {
        rs_robid_t  robid;
        rs_opcode_t opcode;
        rs_prf_id_t pdst;
        rs_data_t   src1_val;
        rs_data_t   src2_val;
    } rs_iss_pkt_t;

endpackage

// File: rs_entry.sv
`timescale 1ns/1ps

`include "rs_defs.svh"

module rs_entry
    import rs_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic               nuke,
    input  logic               alloc,
    input  rs_disp_pkt_t       disp_pkt,
    input  logic [`RS_NUM_WB-1:0] wb_valid,
    input  rs_wb_pkt_t         wb_pkt [`RS_NUM_WB-1:0],
    input  logic               grant,
    output logic               valid,
    output logic               ready,
    output rs_disp_pkt_t       pkt
);

    rs_disp_pkt_t pkt_in;
    rs_disp_pkt_t pkt_nxt;

    // Sets the ready bit on any matching writeback
    function automatic rs_src_t f_wakeup(
        rs_src_t                src,
        logic [`RS_NUM_WB-1:0]  wbv,
        rs_wb_pkt_t             wbp [`RS_NUM_WB-1:0]
    );
        rs_src_t s;
        s = src;
        if (s.optype != OP_REG) begin
            s.ready = 1'b1;
        end
        for (int w = 0; w < `RS_NUM_WB; w++) begin
            if (wbv[w] && (wbp[w].pdst == s.psrc) && (s.optype == OP_REG)) begin
                s.ready = 1'b1;
            end
        end
        return s;
    endfunction

    // New uop on alloc, else keep the held one
    assign pkt_in = alloc ? disp_pkt : pkt;

    always_comb begin
        pkt_nxt      = pkt_in;
        pkt_nxt.src1 = f_wakeup(pkt_in.src1, wb_valid, wb_pkt);
        pkt_nxt.src2 = f_wakeup(pkt_in.src2, wb_valid, wb_pkt);
    end

    always_ff @(posedge clk) begin
        pkt <= pkt_nxt;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= 1'b0;
        end else if (nuke) begin
            valid <= 1'b0;
        end else if (alloc) begin
            valid <= 1'b1;
        end else if (grant) begin
            valid <= 1'b0;
        end
    end

    assign ready = valid && pkt.src1.ready && pkt.src2.ready;

endmodule

// File: rs_ctrl.sv
`timescale 1ns/1ps

`include "rs_defs.svh"

module rs_ctrl
    import rs_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         disp_valid,
    input  logic         nuke,
    input  rs_ent_vec_t  ent_valid,
    input  rs_ent_vec_t  ent_ready,
    input  rs_disp_pkt_t ent_pkt [`RS_NUM_ENTS-1:0],
    output logic         rs_stall,
    output rs_ent_vec_t  alloc,
    output rs_ent_vec_t  grant,
    output logic [1:0]   rd_en,
    output rs_prf_id_t   rd_addr [1:0],
    output rs_disp_pkt_t sel_pkt,
    output logic         iss_valid_s2
);

    // Leave room for a dispatch already past the stall check
    localparam int STALL_THRESH = `RS_NUM_ENTS - `RS_PIPE_SLACK;

    logic [$clog2(`RS_NUM_ENTS):0] valid_cnt;
    rs_ent_vec_t first_free;
    rs_ent_vec_t sel;
    logic        grant_any;
    logic        iss_valid_q;

    // One-hot of the lowest set bit
    function automatic rs_ent_vec_t f_first1(rs_ent_vec_t v);
        rs_ent_vec_t oh;
        oh = '0;
        for (int i = `RS_NUM_ENTS - 1; i >= 0; i--) begin
            if (v[i]) begin
                oh = '0;
                oh[i] = 1'b1;
            end
        end
        return oh;
    endfunction

    assign valid_cnt = $countones(ent_valid);
    assign rs_stall  = valid_cnt >= STALL_THRESH;

    assign first_free = f_first1(~ent_valid);
    assign alloc      = (disp_valid && !nuke) ? first_free : '0;

    // Issue arbitration, lowest index wins
    assign sel       = f_first1(ent_ready);
    assign grant_any = |ent_ready && !nuke;
    assign grant     = grant_any ? sel : '0;

    always_comb begin
        sel_pkt = '0;
        for (int i = 0; i < `RS_NUM_ENTS; i++) begin
            if (sel[i]) begin
                sel_pkt = ent_pkt[i];
            end
        end
    end

    // PRF read for register sources only
    assign rd_en[0]   = grant_any && (sel_pkt.src1.optype == OP_REG);
    assign rd_en[1]   = grant_any && (sel_pkt.src2.optype == OP_REG);
    assign rd_addr[0] = sel_pkt.src1.psrc;
    assign rd_addr[1] = sel_pkt.src2.psrc;

    always_ff @(posedge clk) begin
        if (rst) begin
            iss_valid_q <= 1'b0;
        end else begin
            iss_valid_q <= grant_any;
        end
    end

    // A nuke kills the uop between grant and issue
    assign iss_valid_s2 = iss_valid_q && !nuke;

endmodule

// File: rs_prf.sv
`timescale 1ns/1ps

`include "rs_defs.svh"

module rs_prf
    import rs_pkg::*;
(
    input  logic                  clk,
    input  logic [`RS_NUM_WB-1:0] wb_valid,
    input  rs_wb_pkt_t            wb_pkt [`RS_NUM_WB-1:0],
    input  logic [1:0]            rd_en,
    input  rs_prf_id_t            rd_addr [1:0],
    output rs_data_t              rd_data [1:0]
);

    rs_data_t regs [`RS_PRF_ENTS-1:0];

    // Higher port is written last and wins a conflict
    always_ff @(posedge clk) begin
        for (int w = 0; w < `RS_NUM_WB; w++) begin
            if (wb_valid[w]) begin
                regs[wb_pkt[w].pdst] <= wb_pkt[w].data;
            end
        end
    end

    // Registered reads, held while disabled
    always_ff @(posedge clk) begin
        for (int r = 0; r < 2; r++) begin
            if (rd_en[r]) begin
                rd_data[r] <= regs[rd_addr[r]];
            end
        end
    end

endmodule

// File: rs_issue_stage.sv
`timescale 1ns/1ps

`include "rs_defs.svh"

module rs_issue_stage
    import rs_pkg::*;
(
    input  logic         clk,
    input  rs_disp_pkt_t sel_pkt,
    input  logic         iss_valid_s2,
    input  rs_data_t     rd_data [1:0],
    output logic         ex_iss,
    output rs_iss_pkt_t  ex_iss_pkt,
    output logic         mm_iss,
    output rs_iss_pkt_t  mm_iss_pkt
);

    rs_disp_pkt_t pkt_s2;
    rs_iss_pkt_t  iss_pkt;

    function automatic rs_data_t f_opsel(
        rs_optype_t optype,
        rs_data_t   imm,
        rs_data_t   prf_data
    );
        case (optype)
            OP_REG:  return prf_data;
            OP_IMM:  return imm;
            default: return '0;
        endcase
    endfunction

    always_ff @(posedge clk) begin
        pkt_s2 <= sel_pkt;
    end

    always_comb begin
        iss_pkt.robid    = pkt_s2.robid;
        iss_pkt.opcode   = pkt_s2.opcode;
        iss_pkt.pdst     = pkt_s2.pdst;
        iss_pkt.src1_val = f_opsel(pkt_s2.src1.optype, pkt_s2.imm, rd_data[0]);
        iss_pkt.src2_val = f_opsel(pkt_s2.src2.optype, pkt_s2.imm, rd_data[1]);
    end

    // Unit class picks the strobe
    assign ex_iss = iss_valid_s2 && (pkt_s2.fu == FU_EXE);
    assign mm_iss = iss_valid_s2 && (pkt_s2.fu == FU_MEM);

    assign ex_iss_pkt = iss_pkt;
    assign mm_iss_pkt = iss_pkt;

endmodule

// File: rs_top.sv
`timescale 1ns/1ps

`include "rs_defs.svh"

module rs_top
    import rs_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  disp_valid,
    input  rs_disp_pkt_t          disp_pkt,
    input  logic [`RS_NUM_WB-1:0] wb_valid,
    input  rs_wb_pkt_t            wb_pkt [`RS_NUM_WB-1:0],
    input  logic                  nuke,
    output logic                  rs_stall,
    output logic                  ex_iss,
    output rs_iss_pkt_t           ex_iss_pkt,
    output logic                  mm_iss,
    output rs_iss_pkt_t           mm_iss_pkt
);

    rs_ent_vec_t  alloc;
    rs_ent_vec_t  grant;
    rs_ent_vec_t  ent_valid;
    rs_ent_vec_t  ent_ready;
    rs_disp_pkt_t ent_pkt [`RS_NUM_ENTS-1:0];
    rs_disp_pkt_t sel_pkt;
    logic [1:0]   rd_en;
    rs_prf_id_t   rd_addr [1:0];
    rs_data_t     rd_data [1:0];
    logic         iss_valid_s2;

    rs_ctrl u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .disp_valid   (disp_valid),
        .nuke         (nuke),
        .ent_valid    (ent_valid),
        .ent_ready    (ent_ready),
        .ent_pkt      (ent_pkt),
        .rs_stall     (rs_stall),
        .alloc        (alloc),
        .grant        (grant),
        .rd_en        (rd_en),
        .rd_addr      (rd_addr),
        .sel_pkt      (sel_pkt),
        .iss_valid_s2 (iss_valid_s2)
    );

    for (genvar i = 0; i < `RS_NUM_ENTS; i++) begin : g_ent
        rs_entry u_ent (
            .clk      (clk),
            .rst      (rst),
            .nuke     (nuke),
            .alloc    (alloc[i]),
            .disp_pkt (disp_pkt),
            .wb_valid (wb_valid),
            .wb_pkt   (wb_pkt),
            .grant    (grant[i]),
            .valid    (ent_valid[i]),
            .ready    (ent_ready[i]),
            .pkt      (ent_pkt[i])
        );
    end

    rs_prf u_prf (
        .clk      (clk),
        .wb_valid (wb_valid),
        .wb_pkt   (wb_pkt),
        .rd_en    (rd_en),
        .rd_addr  (rd_addr),
        .rd_data  (rd_data)
    );

    rs_issue_stage u_iss (
        .clk          (clk),
        .sel_pkt      (sel_pkt),
        .iss_valid_s2 (iss_valid_s2),
        .rd_data      (rd_data),
        .ex_iss       (ex_iss),
        .ex_iss_pkt   (ex_iss_pkt),
        .mm_iss       (mm_iss),
        .mm_iss_pkt   (mm_iss_pkt)
    );

endmodule

// File: tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int PERIOD     = 40,
    parameter int RST_CYCLES = 5
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Reset released on a falling edge like the other inputs
    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

// File: tb_rs.sv
`timescale 1ns/1ps

`include "rs_defs.svh"

module tb_rs
    import rs_pkg::*;
();

    localparam int NUM_RAND  = 400;
    localparam int NUM_OPS   = NUM_RAND + 16;
    localparam int NUM_ROBID = 1 << `RS_ROBID_W;
    localparam int STALL_AT  = `RS_NUM_ENTS - `RS_PIPE_SLACK;

    logic                  clk;
    logic                  rst;
    logic                  disp_valid;
    rs_disp_pkt_t          disp_pkt;
    logic [`RS_NUM_WB-1:0] wb_valid;
    rs_wb_pkt_t            wb_pkt [`RS_NUM_WB-1:0];
    logic                  nuke;
    logic                  rs_stall;
    logic                  ex_iss;
    rs_iss_pkt_t           ex_iss_pkt;
    logic                  mm_iss;
    rs_iss_pkt_t           mm_iss_pkt;

    integer       seed = 76;
    int           cyc;
    bit           any_disp;
    int           next_robid;
    rs_data_t     model_regs [`RS_PRF_ENTS];
    bit           outstanding [`RS_PRF_ENTS];
    int           readers [`RS_PRF_ENTS];
    bit           pend [NUM_ROBID];
    rs_disp_pkt_t sb_pkt [NUM_ROBID];
    int           disp_cyc [NUM_ROBID];
    int           iss_cyc [NUM_ROBID];

    tb_clk_gen u_clk_gen (.clk(clk), .rst(rst));

    rs_top u_dut (
        .clk        (clk),
        .rst        (rst),
        .disp_valid (disp_valid),
        .disp_pkt   (disp_pkt),
        .wb_valid   (wb_valid),
        .wb_pkt     (wb_pkt),
        .nuke       (nuke),
        .rs_stall   (rs_stall),
        .ex_iss     (ex_iss),
        .ex_iss_pkt (ex_iss_pkt),
        .mm_iss     (mm_iss),
        .mm_iss_pkt (mm_iss_pkt)
    );

    task automatic end_run_failed();
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic stop_with_msg(string msg);
        $display("ERROR: %s", msg);
        end_run_failed();
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("FAILED: %s expected %h got %h", name, exp, got);
            end_run_failed();
        end
    endtask

    task automatic check_iss_pkt(string name, rs_iss_pkt_t got, rs_iss_pkt_t exp);
        if (got !== exp) begin
            $display("FAILED: %s expected %h got %h", name, exp, got);
            end_run_failed();
        end
    endtask

    function automatic rs_data_t src_value(rs_src_t s, rs_data_t imm);
        if (s.optype == OP_REG) return model_regs[s.psrc];
        if (s.optype == OP_IMM) return imm;
        return '0;
    endfunction

    // Expected issue packet from the model register file
    function automatic rs_iss_pkt_t ref_iss_pkt(rs_robid_t id);
        rs_iss_pkt_t e;
        e.robid    = sb_pkt[id].robid;
        e.opcode   = sb_pkt[id].opcode;
        e.pdst     = sb_pkt[id].pdst;
        e.src1_val = src_value(sb_pkt[id].src1, sb_pkt[id].imm);
        e.src2_val = src_value(sb_pkt[id].src2, sb_pkt[id].imm);
        return e;
    endfunction

    function automatic int pending_count();
        int n;
        n = 0;
        for (int i = 0; i < NUM_ROBID; i++) n += pend[i];
        return n;
    endfunction

    task automatic idle_inputs();
        disp_valid = 1'b0;
        nuke       = 1'b0;
        wb_valid   = '0;
    endtask

    task automatic write_reg(int port, int r, rs_data_t val);
        wb_valid[port]    = 1'b1;
        wb_pkt[port].pdst = r;
        wb_pkt[port].data = val;
        model_regs[r]     = val;
        outstanding[r]    = 1'b0;
    endtask

    // Producers finish at random times on distinct registers
    task automatic drive_writebacks();
        int q [$];
        int pick;
        for (int r = 0; r < `RS_PRF_ENTS; r++) if (outstanding[r]) q.push_back(r);
        for (int w = 0; w < `RS_NUM_WB; w++) begin
            if (q.size() != 0 && ($random(seed) & 3) == 0) begin
                pick = ($random(seed) & 32'h7fff_ffff) % q.size();
                write_reg(w, q[pick], $random(seed));
                q.delete(pick);
            end
        end
    endtask

    task automatic rand_src(output rs_src_t s);
        int r;
        r = $random(seed);
        s.optype = rs_optype_t'((r & 32'h7fff_ffff) % 3);
        s.psrc   = r[12:8];
        s.ready  = (s.optype == OP_REG) ? !outstanding[s.psrc] : r[20];
    endtask

    task automatic make_uop(output rs_disp_pkt_t p);
        int      r;
        rs_src_t s;
        r        = $random(seed);
        p.fu     = r[4] ? FU_MEM : FU_EXE;
        p.opcode = r[3:0];
        p.pdst   = r[9:5];
        p.imm    = $random(seed);
        rand_src(s);
        p.src1 = s;
        rand_src(s);
        p.src2 = s;
        while (pend[next_robid]) next_robid = (next_robid + 1) % NUM_ROBID;
        p.robid    = next_robid;
        next_robid = (next_robid + 1) % NUM_ROBID;
    endtask

    // A dispatch in a nuke cycle is driven but never recorded
    task automatic send_uop(rs_disp_pkt_t p);
        int r;
        disp_valid = 1'b1;
        disp_pkt   = p;
        any_disp   = 1'b1;
        if (!nuke) begin
            pend[p.robid]     = 1'b1;
            sb_pkt[p.robid]   = p;
            disp_cyc[p.robid] = cyc;
            if (p.src1.optype == OP_REG) readers[p.src1.psrc]++;
            if (p.src2.optype == OP_REG) readers[p.src2.psrc]++;
            r = $random(seed);
            if (r[1:0] == 0 && !outstanding[p.pdst] && readers[p.pdst] == 0)
                outstanding[p.pdst] = 1'b1;
        end
    endtask

    task automatic nuke_station();
        nuke = 1'b1;
        for (int i = 0; i < NUM_ROBID; i++) pend[i] = 1'b0;
        for (int r = 0; r < `RS_PRF_ENTS; r++) readers[r] = 0;
    endtask

    task automatic drain(int max_cycles);
        int n;
        n = 0;
        while (pending_count() != 0) begin
            @(negedge clk);
            idle_inputs();
            drive_writebacks();
            n++;
            if (n > max_cycles) stop_with_msg("timeout waiting for pending uops to issue");
        end
    endtask

    always @(posedge clk) begin
        int          held;
        rs_robid_t   id;
        rs_iss_pkt_t got;
        rs_src_t     s;
        if (!rst) begin
            if (!any_disp) begin
                check_bit("rs_stall", rs_stall, 1'b0);
                check_bit("ex_iss", ex_iss, 1'b0);
                check_bit("mm_iss", mm_iss, 1'b0);
            end
            if (ex_iss === 1'b1 || mm_iss === 1'b1) begin
                got = ex_iss ? ex_iss_pkt : mm_iss_pkt;
                id  = got.robid;
                if (!pend[id]) stop_with_msg($sformatf("robid %0d issued but not pending", id));
                check_bit("ex_iss", ex_iss, sb_pkt[id].fu == FU_EXE);
                check_bit("mm_iss", mm_iss, sb_pkt[id].fu == FU_MEM);
                for (int k = 0; k < 2; k++) begin
                    s = k ? sb_pkt[id].src2 : sb_pkt[id].src1;
                    if (s.optype == OP_REG && outstanding[s.psrc])
                        stop_with_msg($sformatf("robid %0d issued before p%0d was written",
                                                id, s.psrc));
                end
                check_iss_pkt(ex_iss ? "ex_iss_pkt" : "mm_iss_pkt", got, ref_iss_pkt(id));
                pend[id]    = 1'b0;
                iss_cyc[id] = cyc;
                if (sb_pkt[id].src1.optype == OP_REG) readers[sb_pkt[id].src1.psrc]--;
                if (sb_pkt[id].src2.optype == OP_REG) readers[sb_pkt[id].src2.psrc]--;
            end
            // Entries held this cycle after the issue above
            if (!nuke) begin
                held = 0;
                for (int i = 0; i < NUM_ROBID; i++) if (pend[i] && disp_cyc[i] < cyc) held++;
                check_bit("rs_stall", rs_stall, held >= STALL_AT);
            end
        end
        cyc++;
    end

    initial begin
        #(NUM_OPS * 50 * 40);
        stop_with_msg("watchdog expired before the test finished");
    end

    initial begin
        rs_disp_pkt_t p;
        int           n_sent;
        int           r;
        cyc = 0;
        any_disp = 1'b0;
        next_robid = 0;
        disp_pkt = '0;
        for (int w = 0; w < `RS_NUM_WB; w++) wb_pkt[w] = '0;
        idle_inputs();
        for (int i = 0; i < NUM_ROBID; i++) pend[i] = 1'b0;
        for (int i = 0; i < `RS_PRF_ENTS; i++) begin
            outstanding[i] = 1'b0;
            readers[i]     = 0;
        end
        wait (rst == 1'b0);
        repeat (4) @(negedge clk);
        for (int i = 0; i < `RS_PRF_ENTS; i += 2) begin
            @(negedge clk);
            idle_inputs();
            write_reg(0, i, $random(seed));
            write_reg(1, i + 1, $random(seed));
        end
        // Lone ready uop into an empty station
        for (int k = 0; k < 4; k++) begin
            drain(100);
            @(negedge clk);
            idle_inputs();
            make_uop(p);
            p.fu = k[0] ? FU_MEM : FU_EXE;
            if (p.src1.optype == OP_REG && !p.src1.ready) p.src1.optype = OP_ZERO;
            if (p.src2.optype == OP_REG && !p.src2.ready) p.src2.optype = OP_ZERO;
            send_uop(p);
            drain(20);
            if (iss_cyc[p.robid] - disp_cyc[p.robid] != 2)
                stop_with_msg($sformatf("robid %0d issued %0d cycles after dispatch, not 2",
                                        p.robid, iss_cyc[p.robid] - disp_cyc[p.robid]));
        end
        // Station filled up to the stall by uops waiting on one late writeback
        for (int i = 0; i < STALL_AT; i++) begin
            @(negedge clk);
            idle_inputs();
            outstanding[9] = 1'b1;
            make_uop(p);
            p.src2 = '{optype: OP_REG, psrc: 5'd9, ready: 1'b0};
            send_uop(p);
        end
        repeat (6) @(negedge clk) idle_inputs();
        write_reg(1, 9, $random(seed));
        drain(100);
        // Parked uops flushed together with a same-cycle dispatch
        for (int i = 0; i < 3; i++) begin
            @(negedge clk);
            idle_inputs();
            outstanding[5] = 1'b1;
            make_uop(p);
            p.src1 = '{optype: OP_REG, psrc: 5'd5, ready: 1'b0};
            send_uop(p);
        end
        @(negedge clk);
        idle_inputs();
        nuke_station();
        make_uop(p);
        send_uop(p);
        @(negedge clk);
        idle_inputs();
        write_reg(0, 5, $random(seed));
        repeat (10) @(negedge clk) idle_inputs();
        n_sent = 0;
        while (n_sent < NUM_RAND) begin
            @(negedge clk);
            idle_inputs();
            drive_writebacks();
            r = $random(seed);
            if (r[9:4] == 0) nuke_station();
            if (!rs_stall && r[1:0] != 0) begin
                make_uop(p);
                send_uop(p);
                n_sent++;
            end
        end
        drain(NUM_RAND * 10);
        @(negedge clk);
        idle_inputs();
        repeat (4) @(negedge clk);
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// File: vlog.f
+incdir+.
rs_pkg.sv
rs_entry.sv
rs_ctrl.sv
rs_prf.sv
rs_issue_stage.sv
rs_top.sv
tb_clk_gen.sv
tb_rs.sv

// File: Bender.yml
package:
  name: rs_sched

sources:
  - include_dirs:
      - .
    files:
      - rs_pkg.sv
      - rs_entry.sv
      - rs_ctrl.sv
      - rs_prf.sv
      - rs_issue_stage.sv
      - rs_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_clk_gen.sv
      - tb_rs.sv
